//--- rename_ckpt_top.f
hw/rename_pkg.sv
hw/br_mask_ctrl.sv
hw/br_stack_ent.sv
hw/branch_stack.sv
hw/map_table.sv
hw/free_list.sv
hw/rename_ckpt_top.sv
tests/rename_ckpt_sva.sv
tests/rename_ckpt_chk.sv
tests/rename_ckpt_tb.sv

//--- tests/rename_ckpt_tb.sv
// Random traffic from a fixed seed; retire returns only displaced registers no longer speculative.
`timescale 1ns/100ps
`default_nettype none

module rename_ckpt_tb;
	import rename_pkg::*;

	localparam int N_STIM      = 2000;         // Random stimulus cycles.
	localparam int TIMEOUT_CYC = N_STIM + 200; // Limit counted from reset release.

	logic                 clk = 1'b0;
	logic                 arst_n_i;
	logic                 disp_valid, disp_is_br, disp_has_dest, res_valid, ret_valid;
	logic [LREG_W-1:0]    disp_lreg, rd_lreg;
	br_state_e            res_state;
	logic [BR_IDX_W-1:0]  res_tag, disp_br_tag, exp_tag;
	logic [PRF_IDX_W-1:0] ret_preg, disp_preg, rd_preg, exp_preg, exp_rd;
	logic                 disp_ready, exp_ready, preg_vld, tag_vld, chk_en;
	logic [BR_MASK_W-1:0] disp_mask, squash_bit, clear_bit, exp_mask, exp_sq, exp_clr;
	int                   err_cnt, chk_cnt, sva_cnt;
	int                   cyc_cnt = 0;
	integer               seed = 32'h38c7_083f;

	// Reference model.
	logic [PRF_IDX_W-1:0] m_map [MT_NUM];
	logic [PRF_IDX_W-1:0] m_fl [PRF_NUM];
	logic [FL_PTR_W-1:0]  m_head, m_tail;
	logic [BR_MASK_W-1:0] m_mask;
	logic [PRF_IDX_W-1:0] ck_map [BR_MASK_W][MT_NUM];
	logic [FL_PTR_W-1:0]  ck_head [BR_MASK_W];
	logic [BR_MASK_W-1:0] ck_mask [BR_MASK_W];
	logic [PRF_IDX_W-1:0] pend_preg [$]; // Displaced under live branches.
	logic [BR_MASK_W-1:0] pend_mask [$];
	logic [PRF_IDX_W-1:0] ret_q [$];     // Free to retire.

	initial begin
		forever #5 clk = ~clk;
	end

	rename_ckpt_top dut_i (
		.clk (clk), .arst_n_i (arst_n_i),
		.disp_valid_i (disp_valid), .disp_ready_o (disp_ready), .disp_is_br_i (disp_is_br),
		.disp_has_dest_i (disp_has_dest), .disp_lreg_i (disp_lreg), .disp_preg_o (disp_preg),
		.disp_mask_o (disp_mask), .disp_br_tag_o (disp_br_tag),
		.res_valid_i (res_valid), .res_state_i (res_state), .res_tag_i (res_tag),
		.squash_bit_o (squash_bit), .clear_bit_o (clear_bit),
		.ret_valid_i (ret_valid), .ret_preg_i (ret_preg),
		.rd_lreg_i (rd_lreg), .rd_preg_o (rd_preg)
	);

	rename_ckpt_chk u_chk (
		.clk (clk), .en_i (chk_en),
		.exp_ready_i (exp_ready), .act_ready_i (disp_ready),
		.preg_vld_i (preg_vld), .exp_preg_i (exp_preg), .act_preg_i (disp_preg),
		.exp_mask_i (exp_mask), .act_mask_i (disp_mask),
		.tag_vld_i (tag_vld), .exp_tag_i (exp_tag), .act_tag_i (disp_br_tag),
		.exp_sq_i (exp_sq), .act_sq_i (squash_bit), .exp_clr_i (exp_clr), .act_clr_i (clear_bit),
		.exp_rd_i (exp_rd), .act_rd_i (rd_preg),
		.chk_cnt_o (chk_cnt), .err_cnt_o (err_cnt)
	);

	assign sva_cnt = dut_i.u_branch_stack.u_sva.fail_cnt;

	function automatic int unsigned rand_below(int unsigned n);
		logic [31:0] r;
		r = $random(seed);
		return r % n;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < MT_NUM; i++) m_map[i] = PRF_IDX_W'(i); // Identity map.
		for (int i = 0; i < PRF_NUM; i++) m_fl[i] = PRF_IDX_W'(MT_NUM + i);
		m_head = '0;
		m_tail = FL_PTR_W'(PRF_NUM - MT_NUM);
		m_mask = '0;
	endtask

	// Drops entries of a squashed branch, clears a resolved bit, frees what is no longer speculative.
	task automatic settle_pending(input logic [BR_MASK_W-1:0] kill, input logic [BR_MASK_W-1:0] clr);
		logic [PRF_IDX_W-1:0] p [$];
		logic [BR_MASK_W-1:0] m [$];
		for (int i = 0; i < pend_preg.size(); i++) begin
			if ((pend_mask[i] & kill) != '0) begin
				// Its dispatch is rolled back, the register is mapped again.
			end else if ((pend_mask[i] & ~clr) == '0) begin
				ret_q.push_back(pend_preg[i]);
			end else begin
				p.push_back(pend_preg[i]);
				m.push_back(pend_mask[i] & ~clr);
			end
		end
		pend_preg = p;
		pend_mask = m;
	endtask

	// Applies the inputs the DUT samples at this edge.
	task automatic step_model();
		logic [PRF_IDX_W-1:0] old;
		logic                 fire;
		fire = disp_valid && exp_ready;
		if (exp_sq != '0) begin
			m_map  = ck_map[res_tag]; // Back to the checkpoint.
			m_head = ck_head[res_tag];
			m_mask = ck_mask[res_tag] & m_mask; // Older clears stay.
			settle_pending(exp_sq, '0);
		end else begin
			m_mask = exp_mask; // Correct clear applied first.
			settle_pending('0, exp_clr);
			if (fire && disp_is_br) begin
				ck_map[exp_tag]  = m_map;
				ck_head[exp_tag] = m_head;
				ck_mask[exp_tag] = m_mask;
				m_mask[exp_tag]  = 1'b1;
			end else if (fire && disp_has_dest) begin
				old              = m_map[disp_lreg];
				m_map[disp_lreg] = m_fl[m_head[PRF_IDX_W-1:0]];
				m_head           = m_head + 1'b1;
				if (m_mask == '0) begin
					ret_q.push_back(old);
				end else begin
					pend_preg.push_back(old);
					pend_mask.push_back(m_mask);
				end
			end
		end
		if (ret_valid) begin
			m_fl[m_tail[PRF_IDX_W-1:0]] = ret_preg; // Push at the tail, even on recovery.
			m_tail = m_tail + 1'b1;
		end
	endtask

	// New inputs and the outputs predicted for them.
	task automatic drive_cycle();
		logic                 v, br, dst, rv, wrong;
		logic [LREG_W-1:0]    lr, rl;
		logic [BR_IDX_W-1:0]  tg, nt;
		logic [BR_MASK_W-1:0] clr, sq, post;
		int unsigned          start;
		if (disp_valid && !exp_ready) begin
			v   = 1'b1; // Refused dispatch is held.
			br  = disp_is_br;
			dst = disp_has_dest;
			lr  = disp_lreg;
		end else begin
			v   = rand_below(4) != 0;
			br  = rand_below(5) == 0;
			dst = rand_below(4) != 0;
			lr  = LREG_W'(rand_below(MT_NUM));
		end
		rl    = LREG_W'(rand_below(MT_NUM));
		rv    = (m_mask != '0) && (rand_below(3) == 0); // Only live branches resolve.
		wrong = rand_below(3) == 0;
		start = rand_below(BR_MASK_W);
		tg    = '0;
		for (int i = BR_MASK_W - 1; i >= 0; i--) begin
			if (m_mask[(start + i) % BR_MASK_W]) tg = BR_IDX_W'((start + i) % BR_MASK_W);
		end
		clr  = (rv && !wrong) ? BR_MASK_W'(1) << tg : '0;
		sq   = (rv && wrong) ? BR_MASK_W'(1) << tg : '0;
		post = m_mask & ~clr;
		nt   = '0;
		for (int i = BR_MASK_W - 1; i >= 0; i--) begin
			if (!post[i]) nt = BR_IDX_W'(i); // Lowest free bit.
		end
		disp_valid    <= v;
		disp_is_br    <= br;
		disp_has_dest <= dst;
		disp_lreg     <= lr;
		rd_lreg       <= rl;
		res_valid     <= rv;
		res_state     <= !rv ? BR_NONE : (wrong ? BR_PR_WRONG : BR_PR_CORRECT);
		res_tag       <= tg;
		ret_valid     <= 1'b0;
		if (ret_q.size() > 0 && rand_below(2) == 0) begin
			ret_valid <= 1'b1;
			ret_preg  <= ret_q.pop_front();
		end
		exp_ready <= (sq == '0) && !(br && (&post)) && !(dst && !br && (m_head == m_tail));
		exp_mask  <= post;
		exp_sq    <= sq;
		exp_clr   <= clr;
		exp_tag   <= nt;
		tag_vld   <= !(&post);
		exp_preg  <= m_fl[m_head[PRF_IDX_W-1:0]];
		preg_vld  <= m_head != m_tail;
		exp_rd    <= m_map[rl];
	endtask

	initial begin
		arst_n_i      = 1'b0;
		chk_en        = 1'b0;
		disp_valid    = 1'b0;
		disp_is_br    = 1'b0;
		disp_has_dest = 1'b0;
		disp_lreg     = '0;
		rd_lreg       = '0;
		res_valid     = 1'b0;
		res_state     = BR_NONE;
		res_tag       = '0;
		ret_valid     = 1'b0;
		ret_preg      = '0;
		model_reset();
		repeat (10) @(posedge clk);
		arst_n_i <= 1'b1;
		chk_en   <= 1'b1;
		drive_cycle();
		repeat (N_STIM) begin
			@(posedge clk);
			step_model();
			drive_cycle();
		end
		@(posedge clk);
		#1;
		$display("Summary: %0d checks, %0d value errors, %0d assertion errors",
			chk_cnt, err_cnt, sva_cnt);
		if (err_cnt == 0 && sva_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Watchdog.
	always @(posedge clk) begin
		if (arst_n_i) begin
			cyc_cnt <= cyc_cnt + 1;
			if (cyc_cnt >= TIMEOUT_CYC) begin
				$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYC);
				$display("*** FAILED ***");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/rename_ckpt_chk.sv
// Compares on the falling edge; preg and tag are only compared while they are defined.
`timescale 1ns/100ps
`default_nettype none

module rename_ckpt_chk (
	input  logic                             clk,
	input  logic                             en_i,        // Checking active.
	input  logic                             exp_ready_i,
	input  logic                             act_ready_i,
	input  logic                             preg_vld_i,  // Free list holds something.
	input  logic [rename_pkg::PRF_IDX_W-1:0] exp_preg_i,
	input  logic [rename_pkg::PRF_IDX_W-1:0] act_preg_i,
	input  logic [rename_pkg::BR_MASK_W-1:0] exp_mask_i,
	input  logic [rename_pkg::BR_MASK_W-1:0] act_mask_i,
	input  logic                             tag_vld_i,   // A mask bit is free.
	input  logic [rename_pkg::BR_IDX_W-1:0]  exp_tag_i,
	input  logic [rename_pkg::BR_IDX_W-1:0]  act_tag_i,
	input  logic [rename_pkg::BR_MASK_W-1:0] exp_sq_i,
	input  logic [rename_pkg::BR_MASK_W-1:0] act_sq_i,
	input  logic [rename_pkg::BR_MASK_W-1:0] exp_clr_i,
	input  logic [rename_pkg::BR_MASK_W-1:0] act_clr_i,
	input  logic [rename_pkg::PRF_IDX_W-1:0] exp_rd_i,
	input  logic [rename_pkg::PRF_IDX_W-1:0] act_rd_i,
	output int                               chk_cnt_o,
	output int                               err_cnt_o
);
	int chk_cnt = 0;
	int err_cnt = 0;

	assign chk_cnt_o = chk_cnt;
	assign err_cnt_o = err_cnt;

	// Case inequality so an X on a port counts as a mismatch.
	task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
		chk_cnt++;
		if (exp_v !== act_v) begin
			err_cnt++;
			$display("FAIL %s: expected %0h, actual %0h at %0t", name, exp_v, act_v, $time);
		end
	endtask

	always @(negedge clk) begin
		if (en_i) begin
			compare("dispatch.ready", exp_ready_i, act_ready_i);
			if (preg_vld_i) begin
				compare("dispatch.preg", exp_preg_i, act_preg_i); // Head of the queue.
			end
			compare("dispatch.mask", exp_mask_i, act_mask_i);
			if (tag_vld_i) begin
				compare("dispatch.br_tag", exp_tag_i, act_tag_i);
			end
			compare("resolve.squash_bit", exp_sq_i, act_sq_i);
			compare("resolve.clear_bit", exp_clr_i, act_clr_i);
			compare("lookup.rd_preg", exp_rd_i, act_rd_i); // Registered map.
		end
	end

endmodule

`default_nettype wire

//--- tests/rename_ckpt_sva.sv
// Bound into branch_stack; covers the resolve vectors and the rename strobe, not the datapath.
`timescale 1ns/100ps
`default_nettype none

module rename_ckpt_sva (
	input logic                             clk,
	input logic                             arst_n_i,
	input logic [rename_pkg::BR_MASK_W-1:0] squash_bit_i, // Wrong resolve vector.
	input logic [rename_pkg::BR_MASK_W-1:0] clear_bit_i,  // Correct resolve vector.
	input logic                             alloc_i,      // Register rename strobe.
	input logic                             disp_ready_i
);
	int fail_cnt = 0; // Assertion failures so far.

	// One resolve kind per cycle.
	a_res_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
			!((|squash_bit_i) && (|clear_bit_i)))
		else begin
			$error("squash_bit and clear_bit are both nonzero");
			fail_cnt++;
		end

	// At most one bit set in each vector.
	a_res_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
			$onehot0(squash_bit_i) && $onehot0(clear_bit_i))
		else begin
			$error("resolve vector has more than one bit set");
			fail_cnt++;
		end

	// A rename needs an accepted dispatch.
	a_alloc_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
			alloc_i |-> disp_ready_i)
		else begin
			$error("alloc_o high while disp_ready_o is low");
			fail_cnt++;
		end

endmodule

bind branch_stack rename_ckpt_sva u_sva (
	.clk          (clk),
	.arst_n_i     (arst_n_i),
	.squash_bit_i (squash_bit_o),
	.clear_bit_i  (clear_bit_o),
	.alloc_i      (alloc_o),
	.disp_ready_i (disp_ready_o)
);

`default_nettype wire

//--- hw/rename_ckpt_top.sv
// One instruction per cycle; resolve and retire are always taken, only dispatch stalls.
`timescale 1ns/100ps
`default_nettype none

module rename_ckpt_top (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic                             disp_valid_i,    // Dispatch handshake.
	output logic                             disp_ready_o,
	input  logic                             disp_is_br_i,
	input  logic                             disp_has_dest_i,
	input  logic [rename_pkg::LREG_W-1:0]    disp_lreg_i,     // Destination register.
	output logic [rename_pkg::PRF_IDX_W-1:0] disp_preg_o,     // Register given out.
	output logic [rename_pkg::BR_MASK_W-1:0] disp_mask_o,     // Branches it depends on.
	output logic [rename_pkg::BR_IDX_W-1:0]  disp_br_tag_o,   // Tag of a new branch.
	input  logic                             res_valid_i,     // Resolve port.
	input  rename_pkg::br_state_e            res_state_i,
	input  logic [rename_pkg::BR_IDX_W-1:0]  res_tag_i,
	output logic [rename_pkg::BR_MASK_W-1:0] squash_bit_o,
	output logic [rename_pkg::BR_MASK_W-1:0] clear_bit_o,
	input  logic                             ret_valid_i,     // Retire port.
	input  logic [rename_pkg::PRF_IDX_W-1:0] ret_preg_i,
	input  logic [rename_pkg::LREG_W-1:0]    rd_lreg_i,       // Lookup port.
	output logic [rename_pkg::PRF_IDX_W-1:0] rd_preg_o
);
	import rename_pkg::*;

	logic                             alloc;          // Rename strobe.
	logic                             fl_empty;
	logic                             rc_valid;       // Recovery strobe.
	logic [MT_NUM-1:0][PRF_IDX_W-1:0] mt_all_data;    // Live map snapshot.
	logic [MT_NUM-1:0][PRF_IDX_W-1:0] rc_mt_all_data; // Restored map.
	logic [FL_PTR_W-1:0]              fl_head;
	logic [FL_PTR_W-1:0]              rc_fl_head;

	branch_stack u_branch_stack (
		.clk              (clk),
		.arst_n_i         (arst_n_i),
		.disp_valid_i     (disp_valid_i),
		.disp_is_br_i     (disp_is_br_i),
		.disp_has_dest_i  (disp_has_dest_i),
		.fl_empty_i       (fl_empty),
		.res_valid_i      (res_valid_i),
		.res_state_i      (res_state_i),
		.res_tag_i        (res_tag_i),
		.bak_mt_data_i    (mt_all_data),
		.bak_fl_head_i    (fl_head),
		.disp_ready_o     (disp_ready_o),
		.alloc_o          (alloc),
		.disp_mask_o      (disp_mask_o),
		.disp_br_tag_o    (disp_br_tag_o),
		.squash_bit_o     (squash_bit_o),
		.clear_bit_o      (clear_bit_o),
		.rc_valid_o       (rc_valid),
		.rc_mt_all_data_o (rc_mt_all_data),
		.rc_fl_head_o     (rc_fl_head)
	);

	map_table u_map_table (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.wr_en_i    (alloc),
		.wr_lreg_i  (disp_lreg_i),
		.wr_preg_i  (disp_preg_o), // Head entry of the free list.
		.rd_lreg_i  (rd_lreg_i),
		.rc_valid_i (rc_valid),
		.rc_data_i  (rc_mt_all_data),
		.rd_preg_o  (rd_preg_o),
		.all_data_o (mt_all_data)
	);

	free_list u_free_list (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.alloc_i     (alloc),
		.free_i      (ret_valid_i),
		.free_preg_i (ret_preg_i),
		.rc_valid_i  (rc_valid),
		.rc_head_i   (rc_fl_head),
		.head_preg_o (disp_preg_o),
		.head_o      (fl_head),
		.empty_o     (fl_empty)
	);

endmodule

`default_nettype wire

//--- hw/free_list.sv
// No overflow check; the source of releases must never push more than the queue holds.
`timescale 1ns/100ps
`default_nettype none

module free_list (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic                             alloc_i,     // Pop at the head.
	input  logic                             free_i,      // Push at the tail.
	input  logic [rename_pkg::PRF_IDX_W-1:0] free_preg_i, // Released register.
	input  logic                             rc_valid_i,  // Head restore.
	input  logic [rename_pkg::FL_PTR_W-1:0]  rc_head_i,
	output logic [rename_pkg::PRF_IDX_W-1:0] head_preg_o, // Next register to hand out.
	output logic [rename_pkg::FL_PTR_W-1:0]  head_o,
	output logic                             empty_o
);
	import rename_pkg::*;

	logic [PRF_IDX_W-1:0] fifo_q [PRF_NUM]; // Queue storage.
	logic [FL_PTR_W-1:0]  head_q;           // Wrap bit on top.
	logic [FL_PTR_W-1:0]  tail_q;

	assign head_preg_o = fifo_q[head_q[PRF_IDX_W-1:0]];
	assign head_o      = head_q;
	assign empty_o     = (head_q == tail_q); // Same index and same wrap.

	// Storage starts with the registers not mapped at reset.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < PRF_NUM; i++) begin
				fifo_q[i] <= PRF_IDX_W'(MT_NUM + i); // Upper half is refilled first.
			end
		end else if (free_i) begin
			fifo_q[tail_q[PRF_IDX_W-1:0]] <= free_preg_i;
		end
	end

	// Pointers.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			head_q <= '0;
			tail_q <= FL_PTR_W'(PRF_NUM - MT_NUM);
		end else begin
			if (rc_valid_i) begin
				head_q <= rc_head_i; // Give back speculative pops.
			end else if (alloc_i) begin
				head_q <= head_q + 1'b1;
			end
			if (free_i) begin
				tail_q <= tail_q + 1'b1; // Also during a restore.
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/map_table.sv
// Restore wins over a rename write; the dispatch gate keeps the two apart anyway.
`timescale 1ns/100ps
`default_nettype none

module map_table (
	input  logic                                                  clk,
	input  logic                                                  arst_n_i,
	input  logic                                                  wr_en_i,   // Rename strobe.
	input  logic [rename_pkg::LREG_W-1:0]                         wr_lreg_i, // Destination.
	input  logic [rename_pkg::PRF_IDX_W-1:0]                      wr_preg_i, // New register.
	input  logic [rename_pkg::LREG_W-1:0]                         rd_lreg_i, // Lookup index.
	input  logic                                                  rc_valid_i,
	input  logic [rename_pkg::MT_NUM-1:0][rename_pkg::PRF_IDX_W-1:0] rc_data_i,
	output logic [rename_pkg::PRF_IDX_W-1:0]                      rd_preg_o,
	output logic [rename_pkg::MT_NUM-1:0][rename_pkg::PRF_IDX_W-1:0] all_data_o
);
	import rename_pkg::*;

	logic [MT_NUM-1:0][PRF_IDX_W-1:0] map_q; // Logical to physical.

	assign rd_preg_o  = map_q[rd_lreg_i]; // Registered map only.
	assign all_data_o = map_q;            // Snapshot for checkpoints.

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			// Identity mapping.
			for (int i = 0; i < MT_NUM; i++) begin
				map_q[i] <= PRF_IDX_W'(i);
			end
		end else if (rc_valid_i) begin
			map_q <= rc_data_i; // Bulk restore.
		end else if (wr_en_i) begin
			map_q[wr_lreg_i] <= wr_preg_i;
		end
	end

endmodule

`default_nettype wire

//--- hw/branch_stack.sv
// Wrong resolve blocks all dispatch that cycle; recovery outputs are zero when idle.
`timescale 1ns/100ps
`default_nettype none

module branch_stack (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic                             disp_valid_i,    // Dispatch request.
	input  logic                             disp_is_br_i,    // Instruction is a branch.
	input  logic                             disp_has_dest_i, // Needs a physical register.
	input  logic                             fl_empty_i,      // Free list has nothing.
	input  logic                             res_valid_i,
	input  rename_pkg::br_state_e            res_state_i,
	input  logic [rename_pkg::BR_IDX_W-1:0]  res_tag_i,
	input  logic [rename_pkg::MT_NUM-1:0][rename_pkg::PRF_IDX_W-1:0] bak_mt_data_i,
	input  logic [rename_pkg::FL_PTR_W-1:0]  bak_fl_head_i,
	output logic                             disp_ready_o,
	output logic                             alloc_o,         // Register rename strobe.
	output logic [rename_pkg::BR_MASK_W-1:0] disp_mask_o,
	output logic [rename_pkg::BR_IDX_W-1:0]  disp_br_tag_o,
	output logic [rename_pkg::BR_MASK_W-1:0] squash_bit_o,
	output logic [rename_pkg::BR_MASK_W-1:0] clear_bit_o,
	output logic                             rc_valid_o,      // Restore this edge.
	output logic [rename_pkg::MT_NUM-1:0][rename_pkg::PRF_IDX_W-1:0] rc_mt_all_data_o,
	output logic [rename_pkg::FL_PTR_W-1:0]  rc_fl_head_o
);
	import rename_pkg::*;

	logic                             full;      // Every slot is taken.
	logic                             disp_fire; // Dispatch handshake.
	logic                             alloc_br;  // Accepted branch.
	logic [BR_MASK_W-1:0]             new_bit;   // Slot capture strobes.
	logic [BR_MASK_W-1:0]             live_mask; // Mask after correct clear.
	logic [BR_MASK_W-1:0]             rc_mask;   // Mask of the selected slot.
	logic [MT_NUM-1:0][PRF_IDX_W-1:0] ent_mt_data [BR_MASK_W];
	logic [FL_PTR_W-1:0]              ent_fl_head [BR_MASK_W];
	logic [BR_MASK_W-1:0]             ent_mask [BR_MASK_W];

	assign rc_valid_o = |squash_bit_o;

	// Ready never looks at valid.
	assign disp_ready_o = !rc_valid_o
			&& !(disp_is_br_i && full)
			&& !(disp_has_dest_i && !disp_is_br_i && fl_empty_i);

	assign disp_fire   = disp_valid_i && disp_ready_o;
	assign alloc_br    = disp_fire && disp_is_br_i;
	assign alloc_o     = disp_fire && !disp_is_br_i && disp_has_dest_i; // Branches skip it.
	assign disp_mask_o = live_mask;

	// Pick the checkpoint of the squashed branch.
	assign rc_mask          = ent_mask[res_tag_i];
	assign rc_mt_all_data_o = rc_valid_o ? ent_mt_data[res_tag_i] : '0;
	assign rc_fl_head_o     = rc_valid_o ? ent_fl_head[res_tag_i] : '0;

	br_mask_ctrl u_mask_ctrl (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.alloc_br_i   (alloc_br),
		.res_valid_i  (res_valid_i),
		.res_state_i  (res_state_i),
		.res_tag_i    (res_tag_i),
		.rc_mask_i    (rc_mask),
		.br_mask_o    (live_mask),
		.new_bit_o    (new_bit),
		.new_tag_o    (disp_br_tag_o),
		.full_o       (full),
		.squash_bit_o (squash_bit_o),
		.clear_bit_o  (clear_bit_o)
	);

	// One slot per mask bit.
	for (genvar i = 0; i < BR_MASK_W; i++) begin : g_ent
		br_stack_ent u_ent (
			.clk           (clk),
			.arst_n_i      (arst_n_i),
			.mask_bit_i    (new_bit[i]),
			.bak_mt_data_i (bak_mt_data_i),
			.bak_fl_head_i (bak_fl_head_i),
			.bak_mask_i    (live_mask),
			.rc_mt_data_o  (ent_mt_data[i]),
			.rc_fl_head_o  (ent_fl_head[i]),
			.rc_mask_o     (ent_mask[i])
		);
	end

endmodule

`default_nettype wire

//--- hw/br_stack_ent.sv
// Slot contents are meaningful only after the slot's mask bit has pulsed once.
`timescale 1ns/100ps
`default_nettype none

module br_stack_ent (
	input  logic                                                  clk,
	input  logic                                                  arst_n_i,
	input  logic                                                  mask_bit_i,    // Capture strobe.
	input  logic [rename_pkg::MT_NUM-1:0][rename_pkg::PRF_IDX_W-1:0] bak_mt_data_i,
	input  logic [rename_pkg::FL_PTR_W-1:0]                       bak_fl_head_i, // Head at branch.
	input  logic [rename_pkg::BR_MASK_W-1:0]                      bak_mask_i,    // Mask it found.
	output logic [rename_pkg::MT_NUM-1:0][rename_pkg::PRF_IDX_W-1:0] rc_mt_data_o,
	output logic [rename_pkg::FL_PTR_W-1:0]                       rc_fl_head_o,
	output logic [rename_pkg::BR_MASK_W-1:0]                      rc_mask_o
);

	// Map copy and head copy.
	always_ff @(posedge clk) begin
		if (mask_bit_i) begin
			rc_mt_data_o <= bak_mt_data_i; // Map before the branch.
			rc_fl_head_o <= bak_fl_head_i; // Head before the branch.
		end
	end

	// Saved dependency mask.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rc_mask_o <= '0;
		end else if (mask_bit_i) begin
			rc_mask_o <= bak_mask_i; // Own bit is never part of it.
		end
	end

endmodule

`default_nettype wire

//--- hw/br_mask_ctrl.sv
// One resolve per cycle; the caller must never allocate a branch during a wrong resolve.
`timescale 1ns/100ps
`default_nettype none

module br_mask_ctrl (
	input  logic                             clk,          // Core clock.
	input  logic                             arst_n_i,     // Async reset, active low.
	input  logic                             alloc_br_i,   // Accepted branch dispatch.
	input  logic                             res_valid_i,  // Resolve strobe.
	input  rename_pkg::br_state_e            res_state_i,  // Resolve outcome.
	input  logic [rename_pkg::BR_IDX_W-1:0]  res_tag_i,    // Tag of the resolved branch.
	input  logic [rename_pkg::BR_MASK_W-1:0] rc_mask_i,    // Saved mask of the squashed branch.
	output logic [rename_pkg::BR_MASK_W-1:0] br_mask_o,    // Live mask after correct clear.
	output logic [rename_pkg::BR_MASK_W-1:0] new_bit_o,    // One-hot bit given to a branch.
	output logic [rename_pkg::BR_IDX_W-1:0]  new_tag_o,    // Index of that bit.
	output logic                             full_o,       // No free bit left.
	output logic [rename_pkg::BR_MASK_W-1:0] squash_bit_o, // Bit of a wrong branch.
	output logic [rename_pkg::BR_MASK_W-1:0] clear_bit_o   // Bit of a correct branch.
);
	import rename_pkg::*;

	logic [BR_MASK_W-1:0] br_mask_q;   // Registered mask.
	logic [BR_MASK_W-1:0] mask_post;   // Mask with this cycle's correct clear.
	logic [BR_MASK_W-1:0] tag_bit;     // Resolved tag as one-hot.
	logic [BR_IDX_W-1:0]  free_idx;    // Lowest zero position.
	logic                 free_found;  // At least one zero exists.
	logic                 res_correct;
	logic                 res_wrong;

	// Decode the resolve port.
	assign tag_bit     = BR_MASK_W'(1) << res_tag_i;
	assign res_correct = res_valid_i && (res_state_i == BR_PR_CORRECT);
	assign res_wrong   = res_valid_i && (res_state_i == BR_PR_WRONG);

	assign clear_bit_o  = res_correct ? tag_bit : '0;
	assign squash_bit_o = res_wrong ? tag_bit : '0;

	// A correct clear is seen by a dispatch in the same cycle.
	assign mask_post = br_mask_q & ~clear_bit_o;
	assign br_mask_o = mask_post;
	assign full_o    = &mask_post; // Freed bit is reusable at once.

	// Priority search, low to high.
	always_comb begin
		free_idx   = '0;
		free_found = 1'b0;
		for (int i = 0; i < BR_MASK_W; i++) begin
			if (!free_found && !mask_post[i]) begin
				free_idx   = BR_IDX_W'(i);
				free_found = 1'b1;
			end
		end
	end

	assign new_tag_o = free_idx;
	// Pulses only for an accepted branch.
	assign new_bit_o = (alloc_br_i && free_found) ? (BR_MASK_W'(1) << free_idx) : '0;

	// Mask register.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			br_mask_q <= '0;
		end else if (res_wrong) begin
			// Younger bits drop, older bits resolved since stay clear.
			br_mask_q <= rc_mask_i & br_mask_q;
		end else begin
			br_mask_q <= mask_post | new_bit_o;
		end
	end

endmodule

`default_nettype wire

//--- hw/rename_pkg.sv
// Sizes are fixed for 8 logical and 16 physical registers with four checkpoints.
`default_nettype none

package rename_pkg;

	// Architectural register file.
	localparam int MT_NUM    = 8;  // Logical registers.
	localparam int LREG_W    = 3;  // Logical index width.

	// Physical register file.
	localparam int PRF_NUM   = 16; // Physical registers.
	localparam int PRF_IDX_W = 4;  // Physical index width.

	// Free-list pointer.
	// Index into a PRF_NUM deep queue plus one wrap bit on top.
	localparam int FL_PTR_W  = 5;

	// Branch checkpoint stack.
	localparam int BR_MASK_W = 4;  // Checkpoint slots, one mask bit each.
	localparam int BR_IDX_W  = 2;  // Branch tag width.

	// Outcome of a branch resolution.
	typedef enum logic [1:0] {
		BR_NONE       = 2'd0, // Nothing resolved.
		BR_PR_CORRECT = 2'd1, // Prediction held, free the bit.
		BR_PR_WRONG   = 2'd2  // Misprediction, restore the checkpoint.
	} br_state_e;

endpackage

`default_nettype wire
